// File: Makefile
# Verilator build and run of the 16-point FFT testbench

VERILATOR ?= verilator
TOP       ?= fft16_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= *** PASSED ***
VFLAGS    ?= --binary --timing --assert -Wno-fatal --timescale 1ns/1ps

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: compile.f
design/fft16_pkg.sv
design/frame_if.sv
design/sample_loader.sv
design/bf4_stage.sv
design/twiddle_stage.sv
design/spectrum_unloader.sv
design/fft16_top.sv
verif/fft16_tb.sv

// File: design/bf4_stage.sv
`default_nettype none

module bf4_stage #(
  parameter int W = fft16_pkg::IN_W_DEFAULT
) (
  input  logic clk,
  input  logic reset_i,
  frame_if.dst frm_i,
  frame_if.src frm_o
);

  localparam int N = fft16_pkg::N_POINTS;
  localparam int R = fft16_pkg::RADIX;
  // First adder level
  localparam int AW = W + 1;
  // Second adder level, equals the output frame width
  localparam int OW = W + fft16_pkg::GROWTH_BITS;

  logic signed [OW-1:0] y_re [N];
  logic signed [OW-1:0] y_im [N];

  //////////////////////////////
  // Four 4-point DFTs
  //////////////////////////////

  for (genvar g = 0; g < R; g++) begin : g_grp
    // Sums and differences of the even and odd input pairs
    logic signed [AW-1:0] a_re;
    logic signed [AW-1:0] a_im;
    logic signed [AW-1:0] b_re;
    logic signed [AW-1:0] b_im;
    logic signed [AW-1:0] c_re;
    logic signed [AW-1:0] c_im;
    logic signed [AW-1:0] d_re;
    logic signed [AW-1:0] d_im;

    // x0 and x2
    assign a_re = AW'(frm_i.re[R*g]) + AW'(frm_i.re[R*g+2]);
    assign a_im = AW'(frm_i.im[R*g]) + AW'(frm_i.im[R*g+2]);
    assign b_re = AW'(frm_i.re[R*g]) - AW'(frm_i.re[R*g+2]);
    assign b_im = AW'(frm_i.im[R*g]) - AW'(frm_i.im[R*g+2]);

    // x1 and x3
    assign c_re = AW'(frm_i.re[R*g+1]) + AW'(frm_i.re[R*g+3]);
    assign c_im = AW'(frm_i.im[R*g+1]) + AW'(frm_i.im[R*g+3]);
    assign d_re = AW'(frm_i.re[R*g+1]) - AW'(frm_i.re[R*g+3]);
    assign d_im = AW'(frm_i.im[R*g+1]) - AW'(frm_i.im[R*g+3]);

    // Bin 0, plain sum
    assign y_re[R*g] = OW'(a_re) + OW'(c_re);
    assign y_im[R*g] = OW'(a_im) + OW'(c_im);

    // Bin 1, b - j*d, the -j is a swap with one negation
    assign y_re[R*g+1] = OW'(b_re) + OW'(d_im);
    assign y_im[R*g+1] = OW'(b_im) - OW'(d_re);

    // Bin 2, alternating signs
    assign y_re[R*g+2] = OW'(a_re) - OW'(c_re);
    assign y_im[R*g+2] = OW'(a_im) - OW'(c_im);

    // Bin 3, b + j*d
    assign y_re[R*g+3] = OW'(b_re) - OW'(d_im);
    assign y_im[R*g+3] = OW'(b_im) + OW'(d_re);
  end

  //////////////////////////////
  // Output register
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      frm_o.valid <= 1'b0;
    end else begin
      frm_o.valid <= frm_i.valid;
    end
  end

  // Payload only loads with a frame
  always_ff @(posedge clk) begin
    if (frm_i.valid) begin
      for (int i = 0; i < N; i++) begin
        frm_o.re[i] <= y_re[i];
        frm_o.im[i] <= y_im[i];
      end
    end
  end

endmodule

`default_nettype wire

// File: design/fft16_pkg.sv
`default_nettype none

package fft16_pkg;

  //////////////////////////////
  // Transform geometry
  //////////////////////////////

  // Samples per frame
  localparam int N_POINTS = 16;

  // Butterfly size, also the number of groups
  localparam int RADIX = 4;

  // Word growth of one 4-point butterfly
  localparam int GROWTH_BITS = 2;

  // Input sample width when the top level is not overridden
  localparam int IN_W_DEFAULT = 16;

  //////////////////////////////
  // Twiddle coefficients
  //////////////////////////////

  // Signed Q1.14, so +1.0 is 16384
  localparam int TW_W = 16;
  localparam int TW_FRAC = 14;

  // Entry k holds cos(2*pi*k/16)
  localparam logic signed [TW_W-1:0] TW_RE [N_POINTS] = '{
     16'sd16384,  16'sd15137,  16'sd11585,  16'sd6270,
     16'sd0,     -16'sd6270,  -16'sd11585, -16'sd15137,
    -16'sd16384, -16'sd15137, -16'sd11585, -16'sd6270,
     16'sd0,      16'sd6270,   16'sd11585,  16'sd15137
  };

  // Entry k holds -sin(2*pi*k/16)
  localparam logic signed [TW_W-1:0] TW_IM [N_POINTS] = '{
     16'sd0,     -16'sd6270,  -16'sd11585, -16'sd15137,
    -16'sd16384, -16'sd15137, -16'sd11585, -16'sd6270,
     16'sd0,      16'sd6270,   16'sd11585,  16'sd15137,
     16'sd16384,  16'sd15137,  16'sd11585,  16'sd6270
  };

endpackage

`default_nettype wire

// File: design/fft16_top.sv
`default_nettype none

module fft16_top #(
  parameter int IN_W = fft16_pkg::IN_W_DEFAULT,
  // After the first butterfly pass
  localparam int MID_W = IN_W + fft16_pkg::GROWTH_BITS,
  // After the second pass
  localparam int OUT_W = MID_W + fft16_pkg::GROWTH_BITS
) (
  input  logic                    clk,
  input  logic                    reset_i,
  input  logic                    in_valid_i,
  input  logic signed [IN_W-1:0]  in_re_i,
  input  logic signed [IN_W-1:0]  in_im_i,
  output logic                    out_valid_o,
  output logic signed [OUT_W-1:0] out_re_o,
  output logic signed [OUT_W-1:0] out_im_o,
  output logic                    out_last_o
);

  //////////////////////////////
  // Frame links between stages
  //////////////////////////////

  frame_if #(.W(IN_W))  ld_frm ();
  frame_if #(.W(MID_W)) bf1_frm ();
  frame_if #(.W(MID_W)) tw_frm ();
  frame_if #(.W(OUT_W)) bf2_frm ();

  // Serial samples to one digit-reversed frame
  sample_loader #(.W(IN_W)) i_sample_loader (
    .clk        (clk),
    .reset_i    (reset_i),
    .in_valid_i (in_valid_i),
    .in_re_i    (in_re_i),
    .in_im_i    (in_im_i),
    .frm_o      (ld_frm)
  );

  // First pass over the n1 index
  bf4_stage #(.W(IN_W)) i_bf4_first (
    .clk     (clk),
    .reset_i (reset_i),
    .frm_i   (ld_frm),
    .frm_o   (bf1_frm)
  );

  // Twiddles and corner turn
  twiddle_stage #(.W(MID_W)) i_twiddle_stage (
    .clk     (clk),
    .reset_i (reset_i),
    .frm_i   (bf1_frm),
    .frm_o   (tw_frm)
  );

  // Second pass over the n2 index
  bf4_stage #(.W(MID_W)) i_bf4_second (
    .clk     (clk),
    .reset_i (reset_i),
    .frm_i   (tw_frm),
    .frm_o   (bf2_frm)
  );

  // Natural-order serial spectrum
  spectrum_unloader #(.W(OUT_W)) i_spectrum_unloader (
    .clk         (clk),
    .reset_i     (reset_i),
    .frm_i       (bf2_frm),
    .out_valid_o (out_valid_o),
    .out_re_o    (out_re_o),
    .out_im_o    (out_im_o),
    .out_last_o  (out_last_o)
  );

endmodule

`default_nettype wire

// File: design/frame_if.sv
`default_nettype none

// One whole complex frame, moved in a single cycle
interface frame_if #(
  parameter int W = fft16_pkg::IN_W_DEFAULT
);

  // High for exactly the one cycle that carries the frame
  logic valid;

  // Slot-indexed payload, slot meaning depends on the stage
  logic signed [W-1:0] re [fft16_pkg::N_POINTS];
  logic signed [W-1:0] im [fft16_pkg::N_POINTS];

  // Producer side
  modport src (output valid, output re, output im);

  // Consumer side, must capture while valid is high
  modport dst (input valid, input re, input im);

endinterface

`default_nettype wire

// File: design/sample_loader.sv
`default_nettype none

module sample_loader #(
  parameter int W = fft16_pkg::IN_W_DEFAULT
) (
  input  logic                clk,
  input  logic                reset_i,
  input  logic                in_valid_i,
  input  logic signed [W-1:0] in_re_i,
  input  logic signed [W-1:0] in_im_i,
  frame_if.src                frm_o
);

  localparam int N = fft16_pkg::N_POINTS;
  localparam int CNT_W = $clog2(N);
  // Bits of one radix-4 digit
  localparam int D_W = $clog2(fft16_pkg::RADIX);

  // Index of the next sample within the frame
  logic [CNT_W-1:0] cnt;
  // Sixteenth sample was taken on the last edge
  logic last_q;
  logic [CNT_W-1:0] wr_slot;

  // Collect buffer, the next frame fills it while the previous one is out
  logic signed [W-1:0] buf_re [N];
  logic signed [W-1:0] buf_im [N];

  // Digit swap, sample n goes to slot 4*(n mod 4) + n div 4
  assign wr_slot = {cnt[D_W-1:0], cnt[CNT_W-1:D_W]};

  always_ff @(posedge clk) begin
    if (reset_i) begin
      cnt    <= '0;
      last_q <= 1'b0;
    end else begin
      last_q <= in_valid_i && (cnt == CNT_W'(N - 1));
      // Wraps to zero after the last sample
      if (in_valid_i) begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid_i) begin
      buf_re[wr_slot] <= in_re_i;
      buf_im[wr_slot] <= in_im_i;
    end
  end

  //////////////////////////////
  // Frame output register
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      frm_o.valid <= 1'b0;
    end else begin
      frm_o.valid <= last_q;
    end
  end

  // Copy of the full buffer, held until the next frame completes
  always_ff @(posedge clk) begin
    if (last_q) begin
      for (int i = 0; i < N; i++) begin
        frm_o.re[i] <= buf_re[i];
        frm_o.im[i] <= buf_im[i];
      end
    end
  end

  // At most one frame per 16 samples
  a_valid_single: assert property (
    @(posedge clk) disable iff (reset_i) frm_o.valid |=> !frm_o.valid
  );

endmodule

`default_nettype wire

// File: design/spectrum_unloader.sv
`default_nettype none

module spectrum_unloader #(
  parameter int W = fft16_pkg::IN_W_DEFAULT
) (
  input  logic                clk,
  input  logic                reset_i,
  frame_if.dst                frm_i,
  output logic                out_valid_o,
  output logic signed [W-1:0] out_re_o,
  output logic signed [W-1:0] out_im_o,
  output logic                out_last_o
);

  localparam int N = fft16_pkg::N_POINTS;
  localparam int CNT_W = $clog2(N);
  localparam int D_W = $clog2(fft16_pkg::RADIX);

  // Next bin to send, zero when idle
  logic [CNT_W-1:0] bin;
  logic [CNT_W-1:0] rd_slot;

  // Held copy of the frame for bins 1 to 15
  logic signed [W-1:0] buf_re [N];
  logic signed [W-1:0] buf_im [N];

  // Bin k sits in slot 4*(k mod 4) + k div 4
  assign rd_slot = {bin[D_W-1:0], bin[CNT_W-1:D_W]};

  //////////////////////////////
  // Bin sequencer
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      bin         <= '0;
      out_valid_o <= 1'b0;
      out_last_o  <= 1'b0;
    end else begin
      out_valid_o <= frm_i.valid || (bin != '0);
      out_last_o  <= (bin == CNT_W'(N - 1));
      if (frm_i.valid) begin
        // Bin 0 leaves with the capture
        bin <= CNT_W'(1);
      end else if (bin != '0) begin
        // Wraps back to idle after bin 15
        bin <= bin + 1'b1;
      end
    end
  end

  //////////////////////////////
  // Frame buffer and output data
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (frm_i.valid) begin
      for (int i = 0; i < N; i++) begin
        buf_re[i] <= frm_i.re[i];
        buf_im[i] <= frm_i.im[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (frm_i.valid) begin
      // Bin 0 is slot 0, straight from the incoming frame
      out_re_o <= frm_i.re[0];
      out_im_o <= frm_i.im[0];
    end else begin
      out_re_o <= buf_re[rd_slot];
      out_im_o <= buf_im[rd_slot];
    end
  end

  // Previous spectrum fully sent before the next frame lands
  a_no_overrun: assert property (
    @(posedge clk) disable iff (reset_i) frm_i.valid |-> (bin == '0)
  );

endmodule

`default_nettype wire

// File: design/twiddle_stage.sv
`default_nettype none

module twiddle_stage #(
  parameter int W = fft16_pkg::IN_W_DEFAULT
) (
  input  logic clk,
  input  logic reset_i,
  frame_if.dst frm_i,
  frame_if.src frm_o
);

  localparam int N = fft16_pkg::N_POINTS;
  localparam int R = fft16_pkg::RADIX;
  localparam int TW_W = fft16_pkg::TW_W;
  localparam int TW_FRAC = fft16_pkg::TW_FRAC;
  // Full product, then one more bit for the sum of two products
  localparam int PW = W + TW_W;
  localparam int SW = PW + 1;
  // Half an output LSB
  localparam logic signed [SW-1:0] RND = SW'(1) << (TW_FRAC - 1);

  // Results already in corner-turned order
  logic signed [W-1:0] y_re [N];
  logic signed [W-1:0] y_im [N];

  //////////////////////////////
  // Twiddle multiply
  //////////////////////////////

  for (genvar n2 = 0; n2 < R; n2++) begin : g_row
    for (genvar k1 = 0; k1 < R; k1++) begin : g_col
      // Source slot, target slot and twiddle index
      localparam int SI = R * n2 + k1;
      localparam int SO = R * k1 + n2;
      localparam int TI = (n2 * k1) % N;

      if (TI == 0) begin : g_pass
        // W^0 is one so no rounding is needed
        assign y_re[SO] = frm_i.re[SI];
        assign y_im[SO] = frm_i.im[SI];
      end else begin : g_mul
        localparam logic signed [TW_W-1:0] WR = fft16_pkg::TW_RE[TI];
        localparam logic signed [TW_W-1:0] WI = fft16_pkg::TW_IM[TI];

        logic signed [PW-1:0] p_rr;
        logic signed [PW-1:0] p_ii;
        logic signed [PW-1:0] p_ri;
        logic signed [PW-1:0] p_ir;
        logic signed [SW-1:0] s_re;
        logic signed [SW-1:0] s_im;
        logic signed [SW-1:0] r_re;
        logic signed [SW-1:0] r_im;

        // Four real products with constant coefficients
        assign p_rr = PW'(frm_i.re[SI]) * PW'(WR);
        assign p_ii = PW'(frm_i.im[SI]) * PW'(WI);
        assign p_ri = PW'(frm_i.re[SI]) * PW'(WI);
        assign p_ir = PW'(frm_i.im[SI]) * PW'(WR);

        assign s_re = SW'(p_rr) - SW'(p_ii);
        assign s_im = SW'(p_ri) + SW'(p_ir);

        // Half away from zero with one less bias on negative sums
        assign r_re = s_re + RND - SW'(s_re[SW-1]);
        assign r_im = s_im + RND - SW'(s_im[SW-1]);

        // Drop the fraction bits
        assign y_re[SO] = r_re[TW_FRAC +: W];
        assign y_im[SO] = r_im[TW_FRAC +: W];
      end
    end
  end

  //////////////////////////////
  // Output register
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      frm_o.valid <= 1'b0;
    end else begin
      frm_o.valid <= frm_i.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (frm_i.valid) begin
      for (int i = 0; i < N; i++) begin
        frm_o.re[i] <= y_re[i];
        frm_o.im[i] <= y_im[i];
      end
    end
  end

  // Output frame one cycle after each input frame and never on adjacent cycles
  a_valid_latency: assert property (
    @(posedge clk) disable iff (reset_i) frm_i.valid |=> (frm_o.valid && !frm_i.valid)
  );

endmodule

`default_nettype wire

// File: verif/fft16_tb.sv
`default_nettype none

module fft16_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int IN_W = fft16_pkg::IN_W_DEFAULT;
  localparam int OUT_W = IN_W + 2 * fft16_pkg::GROWTH_BITS;
  localparam int N = fft16_pkg::N_POINTS;
  localparam int TOL = 4;
  localparam int DRAIN_LIMIT = 400;

  // Frame kinds
  localparam int K_IMPULSE = 0;
  localparam int K_CONST = 1;
  localparam int K_RANDOM = 2;

  // Idle cycles after each sample
  localparam int G_NONE = 0;
  localparam int G_RAND = 1;
  localparam int G_ONE = 2;

  // Random frames with pos nonzero use only the corner values +-amp
  typedef struct packed {
    int kind;
    int amp;
    int pos;
    int gap;
  } stim_t;

  localparam int NUM_STIM = 13;
  localparam stim_t STIM [NUM_STIM] = '{
    '{K_IMPULSE,  12345, 0, G_NONE},
    '{K_IMPULSE, -32768, 0, G_ONE},
    '{K_CONST,     1000, 0, G_NONE},
    '{K_CONST,   -32768, 0, G_NONE},
    '{K_CONST,    32767, 0, G_RAND},
    '{K_IMPULSE,  20000, 1, G_NONE},
    '{K_IMPULSE, -23000, 1, G_RAND},
    '{K_IMPULSE,  15000, 5, G_ONE},
    '{K_RANDOM,   23169, 1, G_NONE},
    '{K_RANDOM,   23169, 0, G_NONE},
    '{K_RANDOM,   23169, 1, G_RAND},
    '{K_RANDOM,    8000, 0, G_ONE},
    '{K_RANDOM,   23169, 0, G_RAND}
  };

  logic                    clk = 1'b0;
  logic                    reset_i;
  logic                    in_valid_i;
  logic signed [IN_W-1:0]  in_re_i;
  logic signed [IN_W-1:0]  in_im_i;
  logic                    out_valid_o;
  logic signed [OUT_W-1:0] out_re_o;
  logic signed [OUT_W-1:0] out_im_o;
  logic                    out_last_o;

  // Current frame in natural sample order
  int x_re [N];
  int x_im [N];

  // Expected spectra, one entry per bin, oldest frame first
  logic signed [OUT_W-1:0] exp_re_q [$];
  logic signed [OUT_W-1:0] exp_im_q [$];
  int tol_q [$];
  // Cycle at which each frame's X[0] is due
  int start_q [$];

  int  cyc = 0;
  int  in_cnt = 0;
  int  bin_idx = -1;
  int  frames_sent = 0;
  int  frames_done = 0;
  int  err_cnt = 0;
  bit  mon_en = 1'b0;

  always #20 clk = ~clk;

  fft16_top #(.IN_W(IN_W)) i_fft16_top (
    .clk         (clk),
    .reset_i     (reset_i),
    .in_valid_i  (in_valid_i),
    .in_re_i     (in_re_i),
    .in_im_i     (in_im_i),
    .out_valid_o (out_valid_o),
    .out_re_o    (out_re_o),
    .out_im_o    (out_im_o),
    .out_last_o  (out_last_o)
  );

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic check_sample(input string name, input logic signed [OUT_W-1:0] act,
                              input logic signed [OUT_W-1:0] exp, input int tol);
    int diff;
    diff = int'(act) - int'(exp);
    if ($isunknown(act) || diff > tol || diff < -tol) begin
      err_cnt++;
      $display("Mismatch %s: got %h, expected %h, tolerance %0d", name, act, exp, tol);
      $display("*** FAILED ***");
      $fatal(1, "Output sample out of tolerance");
    end
  endtask

  task automatic check_flag(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      err_cnt++;
      $display("Mismatch %s: got %h, expected %h", name, act, exp);
      $display("*** FAILED ***");
      $fatal(1, "Control flag wrong");
    end
  endtask

  //////////////////////////////
  // Stimulus and reference
  //////////////////////////////

  function automatic int rand_sym(input int m);
    return int'($urandom_range(2 * m, 0)) - m;
  endfunction

  function automatic int corner(input int m);
    return ($urandom_range(1, 0) != 0) ? m : -m;
  endfunction

  // Half away from zero
  function automatic int round_real(input real r);
    return (r >= 0.0) ? $rtoi(r + 0.5) : $rtoi(r - 0.5);
  endfunction

  task automatic build_frame(input stim_t s);
    for (int n = 0; n < N; n++) begin
      x_re[n] = 0;
      x_im[n] = 0;
      if (s.kind == K_IMPULSE && n == s.pos) begin
        x_re[n] = s.amp;
        x_im[n] = -(s.amp / 2);
      end else if (s.kind == K_CONST) begin
        // Both rails at once for the extreme amplitudes
        x_re[n] = s.amp;
        x_im[n] = -s.amp - 1;
      end else if (s.kind == K_RANDOM) begin
        x_re[n] = (s.pos != 0) ? corner(s.amp) : rand_sym(s.amp);
        x_im[n] = (s.pos != 0) ? corner(s.amp) : rand_sym(s.amp);
      end
    end
  endtask

  // Direct 16-point DFT with the same Q1.14 coefficients as the hardware
  task automatic push_reference(input int tol);
    real acc_re;
    real acc_im;
    real c;
    real s;
    real scale;
    int  idx;
    scale = real'(1 << fft16_pkg::TW_FRAC);
    for (int k = 0; k < N; k++) begin
      acc_re = 0.0;
      acc_im = 0.0;
      for (int n = 0; n < N; n++) begin
        idx = (k * n) % N;
        c = real'(fft16_pkg::TW_RE[idx]) / scale;
        s = real'(fft16_pkg::TW_IM[idx]) / scale;
        acc_re = acc_re + x_re[n] * c - x_im[n] * s;
        acc_im = acc_im + x_re[n] * s + x_im[n] * c;
      end
      exp_re_q.push_back(OUT_W'(round_real(acc_re)));
      exp_im_q.push_back(OUT_W'(round_real(acc_im)));
      tol_q.push_back(tol);
    end
  endtask

  task automatic send_samples(input stim_t s, input int count);
    int gaps;
    for (int n = 0; n < count; n++) begin
      @(posedge clk);
      in_valid_i <= 1'b1;
      in_re_i    <= IN_W'(x_re[n]);
      in_im_i    <= IN_W'(x_im[n]);
      gaps = (s.gap == G_RAND) ? int'($urandom_range(3, 0)) : (s.gap == G_ONE) ? 1 : 0;
      repeat (gaps) begin
        @(posedge clk);
        in_valid_i <= 1'b0;
      end
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    reset_i    <= 1'b1;
    in_valid_i <= 1'b0;
    repeat (5) @(posedge clk);
    reset_i <= 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    @(posedge clk);
    in_valid_i <= 1'b0;
    while (frames_done < frames_sent) begin
      @(posedge clk);
      waited++;
      if (waited > DRAIN_LIMIT) begin
        $display("Timeout: the output never arrived, %0d of %0d frames received",
                 frames_done, frames_sent);
        $display("*** FAILED ***");
        $fatal(1, "Drain timeout");
      end
    end
  endtask

  //////////////////////////////
  // Output monitor
  //////////////////////////////

  // Sampled on the falling edge, halfway between updates
  always @(negedge clk) begin : output_monitor
    int tol;
    cyc++;
    if (reset_i) begin
      in_cnt = 0;
    end else if (in_valid_i === 1'b1) begin
      if (in_cnt == N - 1) begin
        // Accepted on edge cyc+1, X[0] follows five edges later
        start_q.push_back(cyc + 6);
        in_cnt = 0;
      end else begin
        in_cnt++;
      end
    end
    if (mon_en) begin
      if (bin_idx < 0 && start_q.size() > 0 && start_q[0] == cyc) begin
        void'(start_q.pop_front());
        bin_idx = 0;
      end
      if (bin_idx >= 0) begin
        tol = tol_q.pop_front();
        check_flag("out_valid_o", out_valid_o, 1'b1);
        check_flag("out_last_o", out_last_o, bin_idx == N - 1);
        check_sample($sformatf("out_re_o bin %0d", bin_idx), out_re_o, exp_re_q.pop_front(), tol);
        check_sample($sformatf("out_im_o bin %0d", bin_idx), out_im_o, exp_im_q.pop_front(), tol);
        bin_idx++;
        if (bin_idx == N) begin
          bin_idx = -1;
          frames_done++;
        end
      end else begin
        check_flag("out_valid_o", out_valid_o, 1'b0);
        check_flag("out_last_o", out_last_o, 1'b0);
      end
    end
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    int tol;
    reset_i    = 1'b1;
    in_valid_i = 1'b0;
    in_re_i    = '0;
    in_im_i    = '0;
    void'($urandom(32'h74f4e139));
    repeat (5) @(posedge clk);
    reset_i <= 1'b0;
    mon_en = 1'b1;

    // Partial frame thrown away by reset, nothing may come out
    repeat (10) @(posedge clk);
    build_frame(STIM[NUM_STIM - 1]);
    send_samples(STIM[NUM_STIM - 1], 7);
    apply_reset();
    repeat (40) @(posedge clk);

    // Table frames, back to back where the gap pattern allows
    for (int i = 0; i < NUM_STIM; i++) begin
      build_frame(STIM[i]);
      tol = (STIM[i].kind == K_CONST || (STIM[i].kind == K_IMPULSE && STIM[i].pos == 0)) ?
            0 : TOL;
      push_reference(tol);
      send_samples(STIM[i], N);
      frames_sent++;
    end
    wait_drain();
    repeat (20) @(posedge clk);

    if (err_cnt == 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      $display("*** FAILED ***");
      $fatal(1, "Errors were reported");
    end
  end

endmodule

`default_nettype wire
